/* Bender.yml */
package:
  name: hex_dump

sources:
  - capture_pkg.sv
  - ram_if.sv
  - sample_shifter.sv
  - duty_demod.sv
  - capture_ram.sv
  - dump_ctrl.sv
  - uart_tx.sv
  - hex_dump.sv
  - target: test
    files:
      - hex_dump_assert.sv
      - tb_hex_dump.sv

/* capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // captured word width, 16 samples per word
    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;

    // one uart payload byte
    typedef logic [7:0] byte_t;

    // ones per 256-cycle window, saturates at 255
    typedef logic [7:0] duty_t;

    // window count at or above this flags high duty
    localparam duty_t DUTY_THRESH = 8'd96;

    // fill the ram, then read back and send each word as two bytes
    typedef enum logic [2:0] {
        FILL,
        READ,
        SEND_LO,
        SEND_HI,
        IDLE
    } dump_state_t;

endpackage

`default_nettype wire

/* capture_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_ram #(
    parameter int ADDR_W = 8
) (
    input wire logic clk,
    ram_if.mem       ram
);

    localparam int DEPTH = 2 ** ADDR_W;

    capture_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
        end
        ram.rdata <= mem[ram.addr]; // registered read
    end

endmodule

`default_nettype wire

/* dump_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dump_ctrl #(
    parameter int ADDR_W = 8
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire capture_pkg::word_t word,
    input  wire logic               word_stb,
    input  wire logic               rearm,
    input  wire logic               tx_busy,
    output capture_pkg::byte_t      tx_data,
    output logic                    tx_start,
    output logic                    done,
    ram_if.ctrl                     ram
);

    capture_pkg::dump_state_t state;
    logic [ADDR_W-1:0]        addr;
    logic                     last_addr;
    logic                     sending;

    assign last_addr = (addr == {ADDR_W{1'b1}});
    assign sending   = (state == capture_pkg::SEND_LO) || (state == capture_pkg::SEND_HI);

    // writes only while filling, strobes elsewhere are dropped
    assign ram.we    = (state == capture_pkg::FILL) && word_stb;
    assign ram.addr  = addr;
    assign ram.wdata = word;

    // start goes out the same cycle the uart is free
    assign tx_start = sending && !tx_busy;
    assign tx_data  = (state == capture_pkg::SEND_HI) ? ram.rdata[15:8] : ram.rdata[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= capture_pkg::FILL;
            addr  <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                capture_pkg::FILL: begin
                    if (word_stb) begin
                        addr <= addr + 1'b1; // wraps to 0 after the last word
                        if (last_addr) begin
                            state <= capture_pkg::READ;
                            done  <= 1'b1;
                        end
                    end
                end
                capture_pkg::READ: begin
                    state <= capture_pkg::SEND_LO; // rdata lands this edge
                end
                capture_pkg::SEND_LO: begin
                    if (!tx_busy) begin
                        state <= capture_pkg::SEND_HI;
                    end
                end
                capture_pkg::SEND_HI: begin
                    if (!tx_busy) begin
                        addr <= addr + 1'b1;
                        if (last_addr) begin
                            state <= capture_pkg::IDLE;
                        end else begin
                            state <= capture_pkg::READ;
                        end
                    end
                end
                capture_pkg::IDLE: begin
                    if (rearm) begin
                        state <= capture_pkg::FILL;
                        addr  <= '0;
                        done  <= 1'b0;
                    end
                end
                default: begin
                    state <= capture_pkg::FILL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* duty_demod.sv */
`timescale 1ns/10ps
`default_nettype none

module duty_demod (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic sig,
    output logic      high_duty
);

    logic [7:0]         win;
    capture_pkg::duty_t ones;
    capture_pkg::duty_t ones_next;

    // saturate so an all-ones window reads 255
    assign ones_next = (ones == 8'hff) ? ones : ones + capture_pkg::duty_t'(sig);

    always_ff @(posedge clk) begin
        if (rst) begin
            win       <= 8'd0;
            ones      <= '0;
            high_duty <= 1'b0;
        end else begin
            win <= win + 8'd1; // wraps every 256 cycles
            if (win == 8'hff) begin
                high_duty <= (ones_next >= capture_pkg::DUTY_THRESH);
                ones      <= '0;
            end else begin
                ones <= ones_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hex_dump.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_dump #(
    parameter int ADDR_W       = 8,
    parameter int CLKS_PER_BIT = 40000  // 48 MHz at 1200 baud
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic sig,
    input  wire logic rearm,
    output wire logic tx,
    output wire logic high_duty,
    output wire logic done
);

    wire capture_pkg::word_t word;
    wire logic               word_stb;
    wire capture_pkg::byte_t tx_data;
    wire logic               tx_start;
    wire logic               tx_busy;

    ram_if #(.ADDR_W(ADDR_W)) ram_bus ();

    sample_shifter u_shifter (
        .clk      (clk),
        .rst      (rst),
        .sig      (sig),
        .word     (word),
        .word_stb (word_stb)
    );

    duty_demod u_demod (
        .clk       (clk),
        .rst       (rst),
        .sig       (sig),
        .high_duty (high_duty)
    );

    capture_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk (clk),
        .ram (ram_bus.mem)
    );

    dump_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .word     (word),
        .word_stb (word_stb),
        .rearm    (rearm),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .done     (done),
        .ram      (ram_bus.ctrl)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* hex_dump_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_dump_assert (
    input wire logic clk,
    input wire logic rst,
    input wire logic tx_start,
    input wire logic tx_busy,
    input wire logic done,
    input wire logic rearm,
    input wire logic idle,
    input wire logic tx
);

    // start only on a free uart, which then turns busy and ends the pulse
    a_start_when_free: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy ##1 (tx_busy && !tx_start))
        else $error("tx_start while uart busy or not taken by the uart");

    // done only drops on a rearm taken in IDLE
    a_done_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(done) |-> $past(rearm && idle))
        else $error("done fell without rearm in IDLE");

    a_line_idle_high: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> tx)
        else $error("tx low while uart idle");

endmodule

bind dump_ctrl hex_dump_assert u_ctrl_assert (
    .clk(clk), .rst(rst), .tx_start(tx_start), .tx_busy(tx_busy), .done(done),
    .rearm(rearm), .idle(state == capture_pkg::IDLE), .tx(1'b1)
);

bind uart_tx hex_dump_assert u_uart_assert (
    .clk(clk), .rst(rst), .tx_start(tx_start), .tx_busy(tx_busy), .done(1'b1),
    .rearm(1'b0), .idle(1'b0), .tx(tx)
);

`default_nettype wire

/* list.f */
capture_pkg.sv
ram_if.sv
sample_shifter.sv
duty_demod.sv
capture_ram.sv
dump_ctrl.sv
uart_tx.sv
hex_dump.sv
hex_dump_assert.sv
tb_hex_dump.sv

/* ram_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ram_if #(
    parameter int ADDR_W = 8
);

    logic               we;
    logic [ADDR_W-1:0]  addr;
    capture_pkg::word_t wdata;
    capture_pkg::word_t rdata; // valid one cycle after addr

    modport ctrl (
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport mem (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* sample_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_shifter (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   sig,
    output capture_pkg::word_t word,
    output logic        word_stb
);

    capture_pkg::word_t sr;
    logic [3:0]         phase;

    always_ff @(posedge clk) begin
        sr <= {sr[capture_pkg::WORD_W-2:0], sig}; // earliest sample ends in msb
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= 4'd0;
            word_stb <= 1'b0;
        end else begin
            phase    <= phase + 4'd1;
            word_stb <= (phase == 4'd15);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst && phase == 4'd15) begin
            word <= {sr[capture_pkg::WORD_W-2:0], sig}; // include the current sample
        end
    end

endmodule

`default_nettype wire

/* tb_hex_dump.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_hex_dump;

    localparam int ADDR_W       = 5;
    localparam int CLKS_PER_BIT = 8;
    localparam int NWORDS       = 2 ** ADDR_W;
    localparam int CYCLE_LIMIT  = 20000; // two dumps of 64 bytes at ~90 cycles, plus fills

    logic clk = 1'b0;
    logic rst;
    logic sig;
    logic rearm;
    logic tx;
    logic high_duty;
    logic done;

    int                 seed = 32'h89a9_b250;
    bit                 samples[$]; // sig as seen at each edge from cycle 0
    capture_pkg::byte_t rx_q[$];
    int                 errors = 0;
    int                 frame_errs = 0;
    int                 caps_done = 0;
    int                 rearm_at = -1;
    int                 cycles = 0;

    hex_dump #(.ADDR_W(ADDR_W), .CLKS_PER_BIT(CLKS_PER_BIT)) dut (
        .clk(clk), .rst(rst), .sig(sig), .rearm(rearm),
        .tx(tx), .high_duty(high_duty), .done(done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // earliest sample of the word in the msb
    function automatic capture_pkg::word_t word_from_samples(input int k);
        capture_pkg::word_t w;
        for (int i = 0; i < 16; i++) begin
            w[15-i] = samples[16*k+i];
        end
        return w;
    endfunction

    function automatic capture_pkg::duty_t count_window_ones(input int k);
        int cnt;
        cnt = 0;
        for (int i = 0; i < 256; i++) begin
            cnt += samples[256*k+i];
        end
        return (cnt > 255) ? 8'd255 : capture_pkg::duty_t'(cnt);
    endfunction

    initial begin : decode_uart
        capture_pkg::byte_t b;
        logic               start_bit;
        wait (rst === 1'b0);
        forever begin
            @(negedge tx);
            check_equal(done, 1'b1, "done at start bit");
            repeat (CLKS_PER_BIT / 2) @(negedge clk); // middle of the start bit
            start_bit = tx;
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (start_bit !== 1'b0 || tx !== 1'b1) begin
                frame_errs++;
                $display("framing error at %0t: start bit or stop bit has the wrong level", $time);
            end
            rx_q.push_back(b);
        end
    end

    initial begin : compare_bytes
        capture_pkg::byte_t got;
        capture_pkg::word_t w;
        int                 base;
        for (int c = 0; c < 2; c++) begin
            if (c == 1) begin
                wait (rearm_at >= 0); // second dump only follows a rearm
            end
            for (int i = 0; i < 2 * NWORDS; i++) begin
                wait (rx_q.size() > 0);
                got  = rx_q.pop_front();
                base = (c == 0) ? 0 : rearm_at / 16; // first word strobed after rearm
                w    = word_from_samples(base + i / 2);
                check_equal(got, (i % 2 == 0) ? w[7:0] : w[15:8], "dump byte");
            end
            caps_done++;
        end
    end

    initial begin : stimulus
        int   e;
        int   rnd;
        int   idle;
        int   rearms;
        int   done_on;
        int   hi_wins;
        int   lo_wins;
        logic exp_done;
        logic exp_hd;
        idle     = 0;
        rearms   = 0;
        done_on  = 16 * NWORDS;
        hi_wins  = 0;
        lo_wins  = 0;
        exp_done = 1'b0;
        exp_hd   = 1'b0;
        rst      = 1'b1;
        sig      = 1'b0;
        rearm    = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        rnd = $random(seed);
        sig = rnd[0];
        samples.push_back(sig);
        while (!(caps_done == 2 && idle == 100)) begin
            @(posedge clk);
            #2;
            e = samples.size() - 1; // edge just passed
            if (e == done_on || e == rearm_at) begin
                exp_done = (e == done_on);
            end
            if ((e + 1) % 256 == 0) begin
                exp_hd  = (count_window_ones((e + 1) / 256 - 1) >= capture_pkg::DUTY_THRESH);
                hi_wins += exp_hd;
                lo_wins += !exp_hd;
            end
            check_equal(done, exp_done, "done level");
            check_equal(high_duty, exp_hd, "high_duty after window");
            if (e < 16 * NWORDS) begin
                check_equal(tx, 1'b1, "tx idle before dump");
            end
            rearm = 1'b0;
            idle  = (caps_done == rearms + 1) ? idle + 1 : 0;
            if (caps_done == 1 && rearms == 0 && idle == 100) begin
                check_equal(rx_q.size(), 0, "bytes beyond first dump");
                rearm    = 1'b1;
                rearms   = 1;
                rearm_at = e + 1;
                done_on  = 16 * ((e + 1) / 16 + NWORDS); // strobe phase never resets
            end
            if (rearms == 0) begin
                rnd = $random(seed);
                sig = rnd[0];
            end else begin
                sig = ((e + 1) % 5 == 0); // one high in five, low duty
            end
            samples.push_back(sig);
        end
        check_equal(rx_q.size(), 0, "bytes beyond second dump");
        check_equal(hi_wins > 0 && lo_wins > 0, 1'b1, "high and low duty windows");
        $display("errors: %0d value, %0d framing", errors, frame_errs);
        if (errors == 0 && frame_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 40000
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire capture_pkg::byte_t tx_data,
    input  wire logic               tx_start,
    output logic                    tx,
    output logic                    tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       frame; // stop, data lsb first, start
    logic             period_end;

    assign period_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // frame is all ones between bytes so the line idles high
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame   <= '1;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= 4'd0;
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_cnt <= 4'd0;
            if (tx_start) begin
                frame   <= {1'b1, tx_data, 1'b0};
                tx_busy <= 1'b1;
            end
        end else if (period_end) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0; // stop bit done
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire
